// ==== source/wb_pkg.sv ====
package wb_pkg;

   // data widths
   localparam int ADDR_W  = 32;
   localparam int SEG_W   = 16;
   localparam int MM_W    = 64;
   localparam int DR_W    = 3;
   localparam int DSIZE_W = 2;

   // control word carried alongside each micro-op
   localparam int CW_WIDTH = 32;

   // load requests from the control store
   localparam int CW_LD_EIP   = 0;
   localparam int CW_LD_CS    = 1;
   localparam int CW_LD_GPR3  = 2;
   localparam int CW_LD_SEG   = 3;
   localparam int CW_LD_MM    = 4;
   localparam int CW_LD_FLAGS = 5;

   // micro-op kind
   localparam int CW_IS_JNE         = 6;
   localparam int CW_IS_JNBE        = 7;
   localparam int CW_IS_CMOVC       = 8;
   localparam int CW_IS_HALT        = 9;
   localparam int CW_IS_CMPS_SECOND = 10;

   // operand selection
   localparam int CW_SAVE_NEIP     = 11;
   localparam int CW_SAVE_NCS      = 12;
   localparam int CW_USE_TEMP_NEIP = 13;
   localparam int CW_USE_TEMP_NCS  = 14;
   localparam int CW_PUSH_FLAGS    = 15;
   localparam int CW_POP_FLAGS     = 16;

   // affected flags field, bit order CF PF AF ZF SF OF
   localparam int CW_FLAGS_AFF_LO = 17;
   localparam int CW_FLAGS_AFF_W  = 6;

   // bits 23 to 31 of the control word are reserved

   // positions in the EFLAGS word
   localparam int FLAG_CF = 0;
   localparam int FLAG_PF = 2;
   localparam int FLAG_AF = 4;
   localparam int FLAG_ZF = 6;
   localparam int FLAG_SF = 7;
   localparam int FLAG_OF = 11;

   // bit 1 of EFLAGS always reads as one
   localparam logic [ADDR_W-1:0] FLAGS_RESET = 32'h0000_0002;

endpackage

// ==== source/flags_wb.sv ====
`timescale 1ns/1ps

module flags_wb (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        ld_flags_v,
   input  logic [wb_pkg::CW_WIDTH-1:0] cw,
   input  logic [wb_pkg::ADDR_W-1:0]   wb_flags,
   input  logic [wb_pkg::ADDR_W-1:0]   result_a,
   output logic [wb_pkg::ADDR_W-1:0]   final_flags
);
   import wb_pkg::*;

   logic [CW_FLAGS_AFF_W-1:0] aff;
   logic [ADDR_W-1:0]         aff_mask;
   logic [ADDR_W-1:0]         flags_q;

   assign aff = cw[CW_FLAGS_AFF_LO +: CW_FLAGS_AFF_W];

   // spread the compact affected field onto EFLAGS positions
   always_comb begin
      aff_mask          = '0;
      aff_mask[FLAG_CF] = aff[0];
      aff_mask[FLAG_PF] = aff[1];
      aff_mask[FLAG_AF] = aff[2];
      aff_mask[FLAG_ZF] = aff[3];
      aff_mask[FLAG_SF] = aff[4];
      aff_mask[FLAG_OF] = aff[5];
   end

   // popf takes the whole word from the stack value
   always_comb begin
      if (cw[CW_POP_FLAGS]) begin
         final_flags = result_a;
      end else begin
         final_flags = (wb_flags & aff_mask) | (flags_q & ~aff_mask);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flags_q <= FLAGS_RESET;
      end else if (ld_flags_v) begin
         flags_q <= final_flags;
      end
   end

endmodule

// ==== source/operand_select_wb.sv ====
`timescale 1ns/1ps

module operand_select_wb (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        save_v,
   input  logic [wb_pkg::CW_WIDTH-1:0] cw,
   input  logic                        repne,
   input  logic [wb_pkg::ADDR_W-1:0]   result_a,
   input  logic [wb_pkg::ADDR_W-1:0]   result_c,
   input  logic [wb_pkg::ADDR_W-1:0]   neip,
   input  logic [wb_pkg::ADDR_W-1:0]   final_flags,
   input  logic [wb_pkg::SEG_W-1:0]    ncs,
   output logic [wb_pkg::ADDR_W-1:0]   data1,
   output logic [wb_pkg::ADDR_W-1:0]   eip_out,
   output logic [wb_pkg::ADDR_W-1:0]   count_next,
   output logic [wb_pkg::SEG_W-1:0]    cs_out
);
   import wb_pkg::*;

   logic [ADDR_W-1:0] temp_neip;
   logic [SEG_W-1:0]  temp_ncs;
   logic              count_dec;

   // pushf writes the merged flags instead of the alu result
   always_comb begin
      if (cw[CW_PUSH_FLAGS]) begin
         data1 = final_flags;
      end else begin
         data1 = result_a;
      end
   end

   // far call/ret keep the return target across micro-ops
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         temp_neip <= '0;
      end else if (save_v && cw[CW_SAVE_NEIP]) begin
         temp_neip <= neip;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         temp_ncs <= '0;
      end else if (save_v && cw[CW_SAVE_NCS]) begin
         temp_ncs <= ncs;
      end
   end

   always_comb begin
      eip_out = cw[CW_USE_TEMP_NEIP] ? temp_neip : neip;
      cs_out  = cw[CW_USE_TEMP_NCS] ? temp_ncs : ncs;
   end

   // ecx count is decremented only on the second cmps micro-op
   assign count_dec = repne & cw[CW_IS_CMPS_SECOND];

   always_comb begin
      if (count_dec) begin
         count_next = result_c - ADDR_W'(1);
      end else begin
         count_next = result_c;
      end
   end

endmodule

// ==== source/repne_halt_wb.sv ====
`timescale 1ns/1ps

module repne_halt_wb (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wb_v,
   input  logic [wb_pkg::CW_WIDTH-1:0] cw,
   input  logic                        repne,
   input  logic [wb_pkg::ADDR_W-1:0]   final_flags,
   input  logic [wb_pkg::ADDR_W-1:0]   count_next,
   output logic                        halt,
   output logic                        repne_terminate
);
   import wb_pkg::*;

   logic count_zero;

   assign count_zero = (count_next == '0);

   // repne cmps stops on a match or on an exhausted count
   assign repne_terminate = wb_v & repne & cw[CW_IS_CMPS_SECOND] &
                            (final_flags[FLAG_ZF] | count_zero);

   // sticky until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt <= 1'b0;
      end else if (wb_v && cw[CW_IS_HALT]) begin
         halt <= 1'b1;
      end
   end

endmodule

// ==== source/commit_enable_wb.sv ====
`timescale 1ns/1ps

module commit_enable_wb (
   input  logic                        wb_v,
   input  logic                        ex_ld_gpr1,
   input  logic                        ex_ld_gpr2,
   input  logic                        ex_dcache_write,
   input  logic                        repne_terminate,
   input  logic                        write_ready,
   input  logic [wb_pkg::CW_WIDTH-1:0] cw,
   input  logic [wb_pkg::ADDR_W-1:0]   final_flags,
   output logic                        ld_gpr1,
   output logic                        ld_gpr2,
   output logic                        ld_gpr3,
   output logic                        ld_seg,
   output logic                        ld_mm,
   output logic                        ld_eip,
   output logic                        ld_cs,
   output logic                        ld_flags_v,
   output logic                        save_v,
   output logic                        dcache_write,
   output logic                        stall
);
   import wb_pkg::*;

   logic cf;
   logic zf;
   logic jne_ok;
   logic jnbe_ok;
   logic eip_req;
   logic gpr2_req;
   logic ld_ok;
   logic gpr_ok;

   assign cf = final_flags[FLAG_CF];
   assign zf = final_flags[FLAG_ZF];

   // conditional branches only commit eip when taken
   assign jne_ok   = ~cw[CW_IS_JNE] | ~zf;
   assign jnbe_ok  = ~cw[CW_IS_JNBE] | (~cf & ~zf);
   assign eip_req  = cw[CW_LD_EIP] & jne_ok & jnbe_ok;

   // cmovc moves only with carry set
   assign gpr2_req = ex_ld_gpr2 & (~cw[CW_IS_CMOVC] | cf);

   // the cache write is not blocked by its own stall
   assign dcache_write = wb_v & ex_dcache_write & ~repne_terminate;
   assign stall        = dcache_write & ~write_ready;

   assign ld_ok  = wb_v & ~stall;
   assign gpr_ok = ld_ok & ~repne_terminate;

   // gpr loads are dropped on repne termination, eip and flags still go
   assign ld_gpr1    = gpr_ok & ex_ld_gpr1;
   assign ld_gpr2    = gpr_ok & gpr2_req;
   assign ld_gpr3    = gpr_ok & cw[CW_LD_GPR3];
   assign ld_seg     = ld_ok & cw[CW_LD_SEG];
   assign ld_mm      = ld_ok & cw[CW_LD_MM];
   assign ld_eip     = ld_ok & eip_req;
   assign ld_cs      = ld_ok & cw[CW_LD_CS];
   assign ld_flags_v = ld_ok & cw[CW_LD_FLAGS];
   assign save_v     = ld_ok;

endmodule

// ==== source/writeback.sv ====
`timescale 1ns/1ps

module writeback (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        wb_v,
   input  logic [wb_pkg::CW_WIDTH-1:0] cw,
   input  logic [wb_pkg::DSIZE_W-1:0]  datasize,
   input  logic                        ex_ld_gpr1,
   input  logic                        ex_ld_gpr2,
   input  logic                        ex_dcache_write,
   input  logic                        repne,
   input  logic [wb_pkg::ADDR_W-1:0]   result_a,
   input  logic [wb_pkg::ADDR_W-1:0]   result_b,
   input  logic [wb_pkg::ADDR_W-1:0]   result_c,
   input  logic [wb_pkg::ADDR_W-1:0]   wb_flags,
   input  logic [wb_pkg::MM_W-1:0]     result_mm,
   input  logic [wb_pkg::ADDR_W-1:0]   neip,
   input  logic [wb_pkg::SEG_W-1:0]    ncs,
   input  logic [wb_pkg::DR_W-1:0]     dr1,
   input  logic [wb_pkg::DR_W-1:0]     dr2,
   input  logic [wb_pkg::DR_W-1:0]     dr3,
   input  logic [wb_pkg::ADDR_W-1:0]   address,
   input  logic                        write_ready,

   // general register file
   output logic [wb_pkg::DR_W-1:0]     final_dr1,
   output logic [wb_pkg::DR_W-1:0]     final_dr2,
   output logic [wb_pkg::DR_W-1:0]     final_dr3,
   output logic [wb_pkg::ADDR_W-1:0]   final_data1,
   output logic [wb_pkg::ADDR_W-1:0]   final_data2,
   output logic [wb_pkg::ADDR_W-1:0]   final_data3,
   output logic                        ld_gpr1,
   output logic                        ld_gpr2,
   output logic                        ld_gpr3,
   output logic [wb_pkg::DSIZE_W-1:0]  final_datasize,
   output logic                        ld_seg,
   // mm, eip, cs and flags
   output logic [wb_pkg::MM_W-1:0]     mm_data,
   output logic                        ld_mm,
   output logic [wb_pkg::ADDR_W-1:0]   eip,
   output logic                        ld_eip,
   output logic [wb_pkg::SEG_W-1:0]    cs,
   output logic                        ld_cs,
   output logic [wb_pkg::ADDR_W-1:0]   flags,
   output logic                        ld_flags,
   // data cache
   output logic [wb_pkg::MM_W-1:0]     dcache_data,
   output logic [wb_pkg::ADDR_W-1:0]   dcache_address,
   output logic                        dcache_write,
   // dependency checker
   output logic                        dep_ld_gpr1,
   output logic                        dep_ld_gpr2,
   output logic                        dep_ld_gpr3,
   output logic                        dep_ld_seg,
   output logic                        dep_ld_mm,
   output logic                        dep_dcache_write,

   output logic                        halt,
   output logic                        repne_terminate,
   output logic                        stall,
   output logic [wb_pkg::ADDR_W-1:0]   flags_fwd,
   output logic [wb_pkg::ADDR_W-1:0]   count_fwd
);
   import wb_pkg::*;

   logic [ADDR_W-1:0] final_flags;
   logic [ADDR_W-1:0] data1;
   logic [ADDR_W-1:0] count_next;
   logic              save_v;

   flags_wb u_flags_wb (
      .clk         (clk),
      .rst_n       (rst_n),
      .ld_flags_v  (ld_flags),
      .cw          (cw),
      .wb_flags    (wb_flags),
      .result_a    (result_a),
      .final_flags (final_flags)
   );

   operand_select_wb u_operand_select_wb (
      .clk         (clk),
      .rst_n       (rst_n),
      .save_v      (save_v),
      .cw          (cw),
      .repne       (repne),
      .result_a    (result_a),
      .result_c    (result_c),
      .neip        (neip),
      .final_flags (final_flags),
      .ncs         (ncs),
      .data1       (data1),
      .eip_out     (eip),
      .count_next  (count_next),
      .cs_out      (cs)
   );

   repne_halt_wb u_repne_halt_wb (
      .clk             (clk),
      .rst_n           (rst_n),
      .wb_v            (wb_v),
      .cw              (cw),
      .repne           (repne),
      .final_flags     (final_flags),
      .count_next      (count_next),
      .halt            (halt),
      .repne_terminate (repne_terminate)
   );

   commit_enable_wb u_commit_enable_wb (
      .wb_v            (wb_v),
      .ex_ld_gpr1      (ex_ld_gpr1),
      .ex_ld_gpr2      (ex_ld_gpr2),
      .ex_dcache_write (ex_dcache_write),
      .repne_terminate (repne_terminate),
      .write_ready     (write_ready),
      .cw              (cw),
      .final_flags     (final_flags),
      .ld_gpr1         (ld_gpr1),
      .ld_gpr2         (ld_gpr2),
      .ld_gpr3         (ld_gpr3),
      .ld_seg          (ld_seg),
      .ld_mm           (ld_mm),
      .ld_eip          (ld_eip),
      .ld_cs           (ld_cs),
      .ld_flags_v      (ld_flags),
      .save_v          (save_v),
      .dcache_write    (dcache_write),
      .stall           (stall)
   );

   assign final_dr1      = dr1;
   assign final_dr2      = dr2;
   assign final_dr3      = dr3;
   assign final_data1    = data1;
   assign final_data2    = result_b;
   assign final_data3    = result_c;
   assign final_datasize = datasize;
   assign mm_data        = result_mm;
   assign flags          = final_flags;

   // cache port is 64 bits wide, upper half zero
   assign dcache_data    = {{(MM_W-ADDR_W){1'b0}}, data1};
   assign dcache_address = address;

   assign dep_ld_gpr1      = ld_gpr1;
   assign dep_ld_gpr2      = ld_gpr2;
   assign dep_ld_gpr3      = ld_gpr3;
   assign dep_ld_seg       = ld_seg;
   assign dep_ld_mm        = ld_mm;
   assign dep_dcache_write = dcache_write;

   // forwarded to earlier stages in the same cycle
   assign flags_fwd = final_flags;
   assign count_fwd = count_next;

endmodule

// ==== verif/writeback_tb.sv ====
`timescale 1ns/1ps

module writeback_tb;
   import wb_pkg::*;

   localparam int N_OPS        = 2000;
   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;

   logic clk;
   logic rst_n;

   // dut inputs
   logic                 wb_v, ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write, repne, write_ready;
   logic [CW_WIDTH-1:0]  cw;
   logic [DSIZE_W-1:0]   datasize;
   logic [ADDR_W-1:0]    result_a, result_b, result_c, wb_flags, neip, address;
   logic [MM_W-1:0]      result_mm;
   logic [SEG_W-1:0]     ncs;
   logic [DR_W-1:0]      dr1, dr2, dr3;

   // dut outputs
   logic [DR_W-1:0]      final_dr1, final_dr2, final_dr3;
   logic [ADDR_W-1:0]    final_data1, final_data2, final_data3, eip, flags;
   logic [ADDR_W-1:0]    dcache_address, flags_fwd, count_fwd;
   logic [DSIZE_W-1:0]   final_datasize;
   logic [MM_W-1:0]      mm_data, dcache_data;
   logic [SEG_W-1:0]     cs;
   logic                 ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, ld_eip, ld_cs, ld_flags;
   logic                 dcache_write, halt, repne_terminate, stall;
   logic                 dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm;
   logic                 dep_dcache_write;

   // reference model state and expected values
   logic [ADDR_W-1:0]    m_flags, m_temp_neip;
   logic [SEG_W-1:0]     m_temp_ncs;
   logic                 m_halt;
   logic [ADDR_W-1:0]    e_flags, e_data1, e_eip, e_count;
   logic [SEG_W-1:0]     e_cs;
   logic                 e_gpr1, e_gpr2, e_gpr3, e_seg, e_mm, e_eip_ld, e_cs_ld, e_flags_ld;
   logic                 e_dwrite, e_term, e_stall, e_save;

   logic [31:0]          lfsr_state;
   int                   value_errors;
   int                   other_errors;

   writeback dut (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v          = {v[62:0], fb};
      end
      return v;
   endfunction

   task automatic check_bit(input string name, input logic seen, input logic exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %b, expected %b", $time, name, seen, exp);
      end
   endtask

   task automatic check_word(input string name, input logic [ADDR_W-1:0] seen,
                             input logic [ADDR_W-1:0] exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, seen, exp);
      end
   endtask

   task automatic check_seg(input string name, input logic [SEG_W-1:0] seen,
                            input logic [SEG_W-1:0] exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, seen, exp);
      end
   endtask

   task automatic check_dword(input string name, input logic [MM_W-1:0] seen,
                              input logic [MM_W-1:0] exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, seen, exp);
      end
   endtask

   task automatic check_dr(input string name, input logic [DR_W-1:0] seen,
                           input logic [DR_W-1:0] exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, seen, exp);
      end
   endtask

   task automatic check_dsize(input string name, input logic [DSIZE_W-1:0] seen,
                              input logic [DSIZE_W-1:0] exp);
      if (seen !== exp) begin
         value_errors++;
         $display("** Error at %0t: %s = %h, expected %h", $time, name, seen, exp);
      end
   endtask

   task automatic drive_idle();
      wb_v            = 1'b0;
      ex_ld_gpr1      = 1'b0;
      ex_ld_gpr2      = 1'b0;
      ex_dcache_write = 1'b0;
      repne           = 1'b0;
      write_ready     = 1'b1;
      cw              = '0;
      datasize        = '0;
      {result_a, result_b, result_c, wb_flags, neip, address} = '0;
      result_mm       = '0;
      ncs             = '0;
      {dr1, dr2, dr3} = '0;
   endtask

   task automatic drive_random_op();
      logic [1:0] sel;
      wb_v            = (take_bits(2) != 0);
      cw              = CW_WIDTH'(take_bits(CW_WIDTH));
      ex_ld_gpr1      = 1'(take_bits(1));
      ex_ld_gpr2      = 1'(take_bits(1));
      ex_dcache_write = 1'(take_bits(1));
      repne           = 1'(take_bits(1));
      write_ready     = (take_bits(2) != 0);
      datasize        = DSIZE_W'(take_bits(DSIZE_W));
      result_a        = ADDR_W'(take_bits(ADDR_W));
      result_b        = ADDR_W'(take_bits(ADDR_W));
      sel             = 2'(take_bits(2));
      // small counts so that repne reaches zero often
      result_c        = (sel == 0) ? ADDR_W'(take_bits(2)) : ADDR_W'(take_bits(ADDR_W));
      wb_flags        = ADDR_W'(take_bits(ADDR_W));
      result_mm       = take_bits(MM_W);
      neip            = ADDR_W'(take_bits(ADDR_W));
      ncs             = SEG_W'(take_bits(SEG_W));
      address         = ADDR_W'(take_bits(ADDR_W));
      dr1             = DR_W'(take_bits(DR_W));
      dr2             = DR_W'(take_bits(DR_W));
      dr3             = DR_W'(take_bits(DR_W));
   endtask

   task automatic compute_expected();
      int                pos [CW_FLAGS_AFF_W];
      logic [ADDR_W-1:0] mask;
      logic              cf;
      logic              zf;
      logic              ok;
      pos  = '{FLAG_CF, FLAG_PF, FLAG_AF, FLAG_ZF, FLAG_SF, FLAG_OF};
      mask = '0;
      for (int i = 0; i < CW_FLAGS_AFF_W; i++) begin
         mask[pos[i]] = cw[CW_FLAGS_AFF_LO + i];
      end
      e_flags = cw[CW_POP_FLAGS] ? result_a : ((wb_flags & mask) | (m_flags & ~mask));
      cf      = e_flags[FLAG_CF];
      zf      = e_flags[FLAG_ZF];
      e_data1 = cw[CW_PUSH_FLAGS] ? e_flags : result_a;
      e_eip   = cw[CW_USE_TEMP_NEIP] ? m_temp_neip : neip;
      e_cs    = cw[CW_USE_TEMP_NCS] ? m_temp_ncs : ncs;
      e_count = (repne && cw[CW_IS_CMPS_SECOND]) ? result_c - 1 : result_c;
      e_term  = wb_v && repne && cw[CW_IS_CMPS_SECOND] && (zf || e_count == 0);
      e_dwrite = wb_v && ex_dcache_write && !e_term;
      e_stall  = e_dwrite && !write_ready;
      ok       = wb_v && !e_stall;
      e_save   = ok;
      e_eip_ld = ok && cw[CW_LD_EIP];
      if (cw[CW_IS_JNE] && zf) e_eip_ld = 1'b0;
      if (cw[CW_IS_JNBE] && (cf || zf)) e_eip_ld = 1'b0;
      e_gpr1     = ok && !e_term && ex_ld_gpr1;
      e_gpr2     = ok && !e_term && ex_ld_gpr2 && (!cw[CW_IS_CMOVC] || cf);
      e_gpr3     = ok && !e_term && cw[CW_LD_GPR3];
      e_seg      = ok && cw[CW_LD_SEG];
      e_mm       = ok && cw[CW_LD_MM];
      e_cs_ld    = ok && cw[CW_LD_CS];
      e_flags_ld = ok && cw[CW_LD_FLAGS];
   endtask

   task automatic check_outputs();
      check_bit("ld_gpr1", ld_gpr1, e_gpr1);
      check_bit("ld_gpr2", ld_gpr2, e_gpr2);
      check_bit("ld_gpr3", ld_gpr3, e_gpr3);
      check_bit("ld_seg", ld_seg, e_seg);
      check_bit("ld_mm", ld_mm, e_mm);
      check_bit("ld_eip", ld_eip, e_eip_ld);
      check_bit("ld_cs", ld_cs, e_cs_ld);
      check_bit("ld_flags", ld_flags, e_flags_ld);
      check_bit("dcache_write", dcache_write, e_dwrite);
      check_bit("dep_ld_gpr1", dep_ld_gpr1, e_gpr1);
      check_bit("dep_ld_gpr2", dep_ld_gpr2, e_gpr2);
      check_bit("dep_ld_gpr3", dep_ld_gpr3, e_gpr3);
      check_bit("dep_ld_seg", dep_ld_seg, e_seg);
      check_bit("dep_ld_mm", dep_ld_mm, e_mm);
      check_bit("dep_dcache_write", dep_dcache_write, e_dwrite);
      check_bit("halt", halt, m_halt);
      check_bit("repne_terminate", repne_terminate, e_term);
      check_bit("stall", stall, e_stall);
      check_word("final_data1", final_data1, e_data1);
      check_word("final_data2", final_data2, result_b);
      check_word("final_data3", final_data3, result_c);
      check_word("eip", eip, e_eip);
      check_word("flags", flags, e_flags);
      check_word("flags_fwd", flags_fwd, e_flags);
      check_word("count_fwd", count_fwd, e_count);
      check_word("dcache_address", dcache_address, address);
      check_seg("cs", cs, e_cs);
      check_dword("mm_data", mm_data, result_mm);
      check_dword("dcache_data", dcache_data, {{(MM_W-ADDR_W){1'b0}}, e_data1});
      check_dr("final_dr1", final_dr1, dr1);
      check_dr("final_dr2", final_dr2, dr2);
      check_dr("final_dr3", final_dr3, dr3);
      check_dsize("final_datasize", final_datasize, datasize);
   endtask

   // model registers follow the rising edge
   task automatic update_model();
      if (e_flags_ld) m_flags = e_flags;
      if (e_save && cw[CW_SAVE_NEIP]) m_temp_neip = neip;
      if (e_save && cw[CW_SAVE_NCS]) m_temp_ncs = ncs;
      if (wb_v && cw[CW_IS_HALT]) m_halt = 1'b1;
   endtask

   initial begin
      #((N_OPS + 100) * CLK_PERIOD);
      other_errors++;
      $display("watchdog expired before all %0d micro-ops were run", N_OPS);
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      value_errors = 0;
      other_errors = 0;
      lfsr_state   = 32'h7df7_e789;
      m_flags      = FLAGS_RESET;
      m_temp_neip  = '0;
      m_temp_ncs   = '0;
      m_halt       = 1'b0;
      rst_n        = 1'b0;
      drive_idle();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      // state straight out of reset
      compute_expected();
      check_outputs();
      for (int n = 0; n < N_OPS; n++) begin
         @(negedge clk);
         drive_random_op();
         #1;
         compute_expected();
         check_outputs();
         @(posedge clk);
         update_model();
      end
      @(negedge clk);
      drive_idle();
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== writeback.f ====
source/wb_pkg.sv
source/flags_wb.sv
source/operand_select_wb.sv
source/repne_halt_wb.sv
source/commit_enable_wb.sv
source/writeback.sv
verif/writeback_tb.sv

// ==== Bender.yml ====
package:
  name: writeback

sources:
  # package first, then the leaf blocks and the top level
  - source/wb_pkg.sv
  - source/flags_wb.sv
  - source/operand_select_wb.sv
  - source/repne_halt_wb.sv
  - source/commit_enable_wb.sv
  - source/writeback.sv

  - target: test
    files:
      - verif/writeback_tb.sv
